// File: list.f
logic/rv_pkg.sv
logic/alu.sv
logic/datapath.sv
logic/load_store_unit.sv
logic/pc_unit.sv
logic/control_fsm.sv
logic/rv_core.sv
bench/rv_ref_model.sv
bench/rv_core_tb.sv

// File: bench/rv_core_tb.sv
module rv_core_tb import rv_pkg::*;;
    logic        clk, rst_n, instr_valid, dmem_ready, dmem_rvalid;
    logic [31:0] instr, dmem_rdata, imem_addr;
    logic        imem_req, dmem_valid, halted;
    dmem_req_t   dmem_req;

    logic [31:0] imem [256];
    logic [7:0]  dmem [1024];
    logic [31:0] got_addr [$];
    logic [3:0]  got_be [$];
    logic [31:0] got_data [$];
    logic [31:0] read_addr, mask;
    int n_words, res_addr, errors, cycles, limit, fetch_wait, read_wait, steps, seed, k;
    logic halted_seen;
    int br_f3 [6] = '{0, 1, 4, 5, 6, 7};
    int br_rs1 [3] = '{1, 3, 4};   // negative x1 against positive x3, then x4 with itself
    int br_rs2 [3] = '{3, 1, 4};

    rv_core #(.DMEM_ADDR_W(10)) dut (.*);
    rv_ref_model ref_model ();

    function automatic logic [31:0] enc_r(int f7, int rs2, int rs1, int f3, int rd);
        return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), 7'h33};
    endfunction
    function automatic logic [31:0] enc_i(int imm, int rs1, int f3, int rd, logic [6:0] op);
        return {imm[11:0], 5'(rs1), 3'(f3), 5'(rd), op};
    endfunction
    function automatic logic [31:0] enc_s(int imm, int rs2, int rs1, int f3);
        return {imm[11:5], 5'(rs2), 5'(rs1), 3'(f3), imm[4:0], 7'h23};
    endfunction
    function automatic logic [31:0] enc_b(int imm, int rs2, int rs1, int f3);
        return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), 3'(f3), imm[4:1], imm[11], 7'h63};
    endfunction
    function automatic logic [31:0] enc_j(int imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), 7'h6f};
    endfunction

    task automatic emit(input logic [31:0] w);
        imem[n_words] = w;
        n_words++;
    endtask

    task automatic store_result(input int r);
        emit(enc_s(res_addr, r, 0, 2));
        res_addr += 4;
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s got %h expected %h", name, got, exp);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        instr_valid <= 1'b0;
        dmem_rvalid <= 1'b0;
        dmem_ready  <= ($urandom % 3 != 0);   // random back-pressure
        if (rst_n) cycles++;
        if (halted_seen && !halted) begin
            errors++;
            $display("halted dropped after the core had stopped");
        end
        if (halted_seen && imem_req) begin
            errors++;
            $display("instruction fetch seen after the halt word");
        end
        halted_seen = halted_seen || halted;
        if (fetch_wait == 0) begin
            instr       <= imem[imem_addr[9:2]];
            instr_valid <= 1'b1;
        end
        if (fetch_wait >= 0) fetch_wait--;
        if (imem_req) fetch_wait = $urandom % 4;
        if (read_wait == 0) begin
            dmem_rdata  <= {dmem[read_addr + 3], dmem[read_addr + 2],
                            dmem[read_addr + 1], dmem[read_addr]};
            dmem_rvalid <= 1'b1;
        end
        if (read_wait >= 0) read_wait--;
        if (dmem_valid && dmem_ready) begin
            if (dmem_req.write) begin
                mask = {{8{dmem_req.be[3]}}, {8{dmem_req.be[2]}},
                        {8{dmem_req.be[1]}}, {8{dmem_req.be[0]}}};
                got_addr.push_back(dmem_req.addr);
                got_be.push_back(dmem_req.be);
                got_data.push_back(dmem_req.wdata & mask);
                for (int i = 0; i < 4; i++)
                    if (dmem_req.be[i]) dmem[{dmem_req.addr[9:2], 2'(i)}] = dmem_req.wdata[8*i +: 8];
            end else begin
                read_addr = {dmem_req.addr[31:2], 2'b00};
                read_wait = $urandom % 4;
            end
        end
        if (limit > 0 && cycles >= limit) begin
            $display("timeout, core did not halt within %0d cycles", limit);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        seed = $urandom(32'h1109_11f8);
        {rst_n, instr, instr_valid, dmem_ready, dmem_rvalid, dmem_rdata} = '0;
        {n_words, errors, cycles, limit, k} = '0;
        fetch_wait = -1;
        read_wait = -1;
        read_addr = 32'h0;
        halted_seen = 1'b0;
        res_addr = 32'h180;
        for (int i = 0; i < 256; i++) imem[i] = 32'h0;
        for (int i = 0; i < 1024; i++) dmem[i] = 8'((i * 29) ^ (i >> 4));
        emit({20'h80000, 5'd1, 7'h37});
        emit(enc_i(5, 1, 0, 1, 7'h13));
        emit(enc_i(-3, 0, 0, 2, 7'h13));
        emit(enc_i(31, 0, 0, 3, 7'h13));
        emit(enc_i(7, 0, 0, 4, 7'h13));
        for (int f3 = 0; f3 < 8; f3++) begin
            emit(enc_r(0, 4, 1, f3, 5));
            store_result(5);
            emit(enc_r(0, 1, 4, f3, 5));
            store_result(5);
        end
        emit(enc_r(32, 2, 1, 0, 5));
        store_result(5);
        emit(enc_r(32, 3, 1, 5, 5));   // sra by 31
        store_result(5);
        emit(enc_r(0, 3, 1, 1, 5));
        store_result(5);
        emit(enc_r(0, 0, 1, 5, 5));    // srl by 0
        store_result(5);
        for (int f3 = 0; f3 < 8; f3++) begin
            if (f3 != 1 && f3 != 5) begin
                emit(enc_i(-3, 3, f3, 5, 7'h13));
                store_result(5);
            end
        end
        for (int s = 0; s < 2; s++) begin
            emit(enc_i(s * 31, 1, 1, 5, 7'h13));
            store_result(5);
            emit(enc_i(s * 31, 1, 5, 5, 7'h13));
            store_result(5);
            emit(enc_i(1024 + s * 31, 1, 5, 5, 7'h13));
            store_result(5);
        end
        for (int off = 0; off < 8; off++) begin
            emit(enc_i(32'h100 + off, 0, 0, 5, 7'h03));
            store_result(5);
            emit(enc_i(32'h100 + off, 0, 4, 5, 7'h03));
            store_result(5);
            if (off % 2 == 0) begin
                emit(enc_i(32'h100 + off, 0, 1, 5, 7'h03));
                store_result(5);
                emit(enc_i(32'h100 + off, 0, 5, 5, 7'h03));
                store_result(5);
            end
            emit(enc_s(32'h300 + off, 1, 0, 0));
        end
        emit(enc_i(32'h104, 0, 2, 5, 7'h03));
        store_result(5);
        emit(enc_s(32'h310, 1, 0, 1));
        emit(enc_s(32'h312, 1, 0, 1));
        emit(enc_s(32'h320, 1, 0, 2));
        foreach (br_f3[i]) begin
            foreach (br_rs1[p]) begin
                emit(enc_b(12, br_rs2[p], br_rs1[p], br_f3[i]));
                emit(enc_i(32'h100 + k, 0, 0, 6, 7'h13));   // not-taken marker
                emit(enc_j(8, 0));
                emit(enc_i(32'h200 + k, 0, 0, 6, 7'h13));   // taken marker
                store_result(6);
                k++;
            end
        end
        emit(enc_j(8, 7));
        emit(enc_i(32'h7ff, 0, 0, 7, 7'h13));
        store_result(7);
        emit({20'h12345, 5'd8, 7'h17});
        store_result(8);
        emit(enc_i(4 * n_words + 13, 0, 0, 10, 7'h13));   // odd jalr target
        emit(enc_i(0, 10, 0, 9, 7'h67));
        emit(enc_i(32'h7ff, 0, 0, 9, 7'h13));
        store_result(9);
        store_result(10);
        emit(32'h0);
        for (int i = 0; i < 256; i++) ref_model.imem[i] = imem[i];
        for (int i = 0; i < 1024; i++) ref_model.dmem[i] = dmem[i];
        steps = ref_model.run_program();
        limit = steps * 12 + 200;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        while (!halted) @(posedge clk);
        repeat (20) @(posedge clk);
        if (got_addr.size() != ref_model.exp_addr.size()) begin
            errors++;
            $display("store count differs, %0d seen and %0d expected",
                     got_addr.size(), ref_model.exp_addr.size());
        end
        for (int i = 0; i < got_addr.size() && i < ref_model.exp_addr.size(); i++) begin
            check("dmem_req.addr", got_addr[i], ref_model.exp_addr[i]);
            check("dmem_req.be", 32'(got_be[i]), 32'(ref_model.exp_be[i]));
            check("dmem_req.wdata", got_data[i], ref_model.exp_data[i]);
        end
        check("imem_addr", imem_addr, ref_model.final_pc);
        check("halted", 32'(halted), 32'h1);
        for (int i = 0; i < 1024; i += 4)
            check("dmem", {dmem[i + 3], dmem[i + 2], dmem[i + 1], dmem[i]},
                  {ref_model.dmem[i + 3], ref_model.dmem[i + 2],
                   ref_model.dmem[i + 1], ref_model.dmem[i]});
        $display("%0d errors over %0d stores", errors, got_addr.size());
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end
endmodule

// File: bench/rv_ref_model.sv
module rv_ref_model;
    logic [31:0] imem [256];
    logic [7:0]  dmem [1024];
    logic [31:0] exp_addr [$];
    logic [3:0]  exp_be [$];
    logic [31:0] exp_data [$];
    logic [31:0] final_pc;

    function automatic logic [31:0] int_op(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'h0, $signed(a) < $signed(b)};
            3'd3: return {31'h0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // interprets imem until the zero word, returns the instruction count
    function automatic int run_program();
        logic [31:0] x [32];
        logic [31:0] pc, nxt, w, a, b, imm_i, imm_s, imm_b, imm_u, imm_j, addr, data, mask;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [3:0]  be;
        logic        taken;
        int          steps;
        for (int i = 0; i < 32; i++) x[i] = 32'h0;
        pc = 32'h0;
        steps = 0;
        while (imem[pc[9:2]] != 32'h0 && steps < 5000) begin
            w = imem[pc[9:2]];
            f3 = w[14:12];
            rd = w[11:7];
            a = x[w[19:15]];
            b = x[w[24:20]];
            imm_i = {{20{w[31]}}, w[31:20]};
            imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
            imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            imm_u = {w[31:12], 12'h0};
            imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            nxt = pc + 4;
            addr = (a + ((w[6:0] == 7'h23) ? imm_s : imm_i)) & 32'h3ff;
            case (w[6:0])
                7'h33: x[rd] = int_op(f3, w[30], a, b);
                7'h13: x[rd] = int_op(f3, w[30] && f3 == 3'd5, a, imm_i);
                7'h03: begin
                    data = {dmem[addr + 3], dmem[addr + 2], dmem[addr + 1], dmem[addr]};
                    case (f3)
                        3'd0: x[rd] = {{24{data[7]}}, data[7:0]};
                        3'd1: x[rd] = {{16{data[15]}}, data[15:0]};
                        3'd4: x[rd] = {24'h0, data[7:0]};
                        3'd5: x[rd] = {16'h0, data[15:0]};
                        default: x[rd] = data;
                    endcase
                end
                7'h23: begin
                    be = ((f3 == 3'd0) ? 4'b0001 : (f3 == 3'd1) ? 4'b0011 : 4'b1111) << addr[1:0];
                    data = b << (8 * addr[1:0]);
                    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
                    for (int i = 0; i < 4; i++)
                        if (be[i]) dmem[{addr[9:2], 2'(i)}] = data[8*i +: 8];
                    exp_addr.push_back(addr);
                    exp_be.push_back(be);
                    exp_data.push_back(data & mask);
                end
                7'h63: begin
                    case (f3)
                        3'd0: taken = (a == b);
                        3'd1: taken = (a != b);
                        3'd4: taken = $signed(a) < $signed(b);
                        3'd5: taken = $signed(a) >= $signed(b);
                        3'd6: taken = a < b;
                        default: taken = a >= b;
                    endcase
                    if (taken) nxt = pc + imm_b;
                end
                7'h6f: begin
                    x[rd] = pc + 4;
                    nxt = pc + imm_j;
                end
                7'h67: begin
                    nxt = (a + imm_i) & ~32'h1;   // target uses rs1 before the link write
                    x[rd] = pc + 4;
                end
                7'h37: x[rd] = imm_u;
                default: x[rd] = pc + imm_u;   // auipc
            endcase
            x[0] = 32'h0;
            pc = nxt;
            steps++;
        end
        final_pc = pc;
        return steps;
    endfunction
endmodule

// File: logic/rv_core.sv
module rv_core import rv_pkg::*; #(
    parameter int DMEM_ADDR_W = 10
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] instr,
    input  logic        instr_valid,
    input  logic        dmem_ready,
    input  logic        dmem_rvalid,
    input  logic [31:0] dmem_rdata,
    output logic        imem_req,
    output logic [31:0] imem_addr,
    output logic        dmem_valid,
    output dmem_req_t   dmem_req,
    output logic        halted
);
    ctrl_t       ctrl;
    pc_sel_e     pc_sel;
    logic        pc_en;
    logic [31:0] pc;
    logic [31:0] alu_result;
    logic [31:0] rs2_data;
    logic        zero;
    logic [31:0] store_wdata;
    logic [3:0]  store_be;
    logic [31:0] load_data;

    assign imem_addr = pc;

    control_fsm #(.DMEM_ADDR_W(DMEM_ADDR_W)) u_control_fsm (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .instr_valid (instr_valid),
        .pc          (pc),
        .alu_result  (alu_result),
        .zero        (zero),
        .dmem_ready  (dmem_ready),
        .dmem_rvalid (dmem_rvalid),
        .store_wdata (store_wdata),
        .store_be    (store_be),
        .imem_req    (imem_req),
        .ctrl        (ctrl),
        .pc_sel      (pc_sel),
        .pc_en       (pc_en),
        .dmem_valid  (dmem_valid),
        .dmem_req    (dmem_req),
        .halted      (halted)
    );

    datapath u_datapath (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl       (ctrl),
        .load_data  (load_data),
        .pc         (pc),
        .alu_result (alu_result),
        .rs2_data   (rs2_data),
        .zero       (zero),
        .negative   (),
        .overflow   ()
    );

    pc_unit u_pc_unit (
        .clk          (clk),
        .rst_n        (rst_n),
        .pc_en        (pc_en),
        .pc_sel       (pc_sel),
        .imm          (ctrl.imm),
        .rs1_plus_imm (alu_result),
        .pc           (pc)
    );

    load_store_unit #(.DMEM_ADDR_W(DMEM_ADDR_W)) u_load_store_unit (
        .addr_low  (alu_result[DMEM_ADDR_W-1:0]),
        .funct3    (ctrl.funct3),
        .rs2_data  (rs2_data),
        .rdata     (dmem_rdata),
        .wdata     (store_wdata),
        .be        (store_be),
        .load_data (load_data)
    );

endmodule

// File: logic/control_fsm.sv
module control_fsm import rv_pkg::*; #(
    parameter int DMEM_ADDR_W = 10
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] instr,
    input  logic        instr_valid,
    input  logic [31:0] pc,
    input  logic [31:0] alu_result,
    input  logic        zero,
    input  logic        dmem_ready,
    input  logic        dmem_rvalid,
    input  logic [31:0] store_wdata,
    input  logic [3:0]  store_be,
    output logic        imem_req,
    output ctrl_t       ctrl,
    output pc_sel_e     pc_sel,
    output logic        pc_en,
    output logic        dmem_valid,
    output dmem_req_t   dmem_req,
    output logic        halted
);
    core_state_e state;
    logic [31:0] instr_q;
    logic        fetch_sent;   // imem_req already pulsed for this fetch
    logic        br_taken;
    logic        taken;
    opcode_e     opcode;
    logic [2:0]  funct3;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;

    assign opcode = opcode_e'(instr_q[6:0]);
    assign funct3 = instr_q[14:12];

    assign imm_i = {{20{instr_q[31]}}, instr_q[31:20]};
    assign imm_s = {{20{instr_q[31]}}, instr_q[31:25], instr_q[11:7]};
    assign imm_b = {{20{instr_q[31]}}, instr_q[7], instr_q[30:25], instr_q[11:8], 1'b0};
    assign imm_u = {instr_q[31:12], 12'h0};
    assign imm_j = {{12{instr_q[31]}}, instr_q[19:12], instr_q[20], instr_q[30:21], 1'b0};

    always_comb begin
        ctrl.rs1     = instr_q[19:15];
        ctrl.rs2     = instr_q[24:20];
        ctrl.rd      = instr_q[11:7];
        ctrl.funct3  = funct3;
        ctrl.alu_op  = alu_add;   // address and jalr target sums
        ctrl.use_imm = 1'b1;
        ctrl.wb_sel  = wb_alu;
        ctrl.imm     = imm_i;
        case (opcode)
            op_r: begin
                ctrl.alu_op  = alu_op_e'({instr_q[30], funct3});
                ctrl.use_imm = 1'b0;
            end
            op_i: ctrl.alu_op = alu_op_e'({instr_q[30] && funct3 == F3_SR, funct3});
            op_load:  ctrl.wb_sel = wb_load;
            op_store: ctrl.imm = imm_s;
            op_branch: begin
                ctrl.use_imm = 1'b0;
                ctrl.imm     = imm_b;
                case (funct3)
                    F3_BLT, F3_BGE:   ctrl.alu_op = alu_slt;
                    F3_BLTU, F3_BGEU: ctrl.alu_op = alu_sltu;
                    default:          ctrl.alu_op = alu_sub;
                endcase
            end
            op_jal: begin
                ctrl.imm    = imm_j;
                ctrl.wb_sel = wb_link;
            end
            op_jalr: ctrl.wb_sel = wb_link;
            op_lui: begin
                ctrl.imm    = imm_u;
                ctrl.wb_sel = wb_imm;
            end
            op_auipc: begin
                ctrl.imm    = imm_u + pc;
                ctrl.wb_sel = wb_imm;
            end
            default: ;
        endcase
        // jumps write the link on the pc edge so jalr still reads the old rs1
        case (state)
            st_write_back: ctrl.reg_write = opcode inside {op_r, op_i, op_lui, op_auipc};
            st_next_pc:    ctrl.reg_write = opcode inside {op_jal, op_jalr};
            st_mem_wait:   ctrl.reg_write = dmem_rvalid && opcode == op_load;
            default:       ctrl.reg_write = 1'b0;
        endcase
    end

    always_comb begin
        case (funct3)
            F3_BEQ:           taken = zero;
            F3_BNE:           taken = !zero;
            F3_BLT, F3_BLTU:  taken = (alu_result == 32'd1);
            F3_BGE, F3_BGEU:  taken = (alu_result != 32'd1);
            default:          taken = 1'b0;
        endcase
    end

    always_comb begin
        case (opcode)
            op_jal:    pc_sel = pc_plus_imm;
            op_jalr:   pc_sel = pc_reg_plus_imm;
            op_branch: pc_sel = br_taken ? pc_plus_imm : pc_plus4;
            default:   pc_sel = pc_plus4;
        endcase
    end

    assign pc_en = (state == st_next_pc);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= st_fetch;
            imem_req   <= 1'b0;
            fetch_sent <= 1'b0;
            br_taken   <= 1'b0;
            dmem_valid <= 1'b0;
            halted     <= 1'b0;
        end else begin
            case (state)
                st_fetch: begin
                    imem_req   <= !fetch_sent;   // one cycle pulse
                    fetch_sent <= 1'b1;
                    if (instr_valid) begin
                        imem_req   <= 1'b0;
                        fetch_sent <= 1'b0;
                        state      <= st_decode;
                    end
                end
                st_decode: begin
                    if (opcode == op_halt) begin
                        halted <= 1'b1;
                        state  <= st_halt;
                    end else begin
                        state  <= st_execute;
                    end
                end
                st_execute: begin
                    case (opcode)
                        op_load, op_store: begin
                            dmem_valid <= 1'b1;
                            state      <= st_mem_req;
                        end
                        op_branch: state <= st_branch;
                        default:   state <= st_write_back;
                    endcase
                end
                st_write_back: state <= st_next_pc;
                st_branch: begin
                    br_taken <= taken;
                    state    <= st_next_pc;
                end
                st_mem_req: begin
                    if (dmem_ready) begin
                        dmem_valid <= 1'b0;
                        state      <= (opcode == op_load) ? st_mem_wait : st_next_pc;
                    end
                end
                st_mem_wait: begin
                    if (dmem_rvalid) begin
                        state <= st_next_pc;
                    end
                end
                st_next_pc: state <= st_fetch;
                st_halt:    state <= st_halt;   // only reset leaves
                default:    state <= st_fetch;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_fetch && instr_valid) begin
            instr_q <= instr;
        end
        if (state == st_execute) begin
            dmem_req.addr  <= {{(32 - DMEM_ADDR_W){1'b0}}, alu_result[DMEM_ADDR_W-1:0]};
            dmem_req.write <= (opcode == op_store);
            dmem_req.be    <= store_be;
            dmem_req.wdata <= store_wdata;
        end
    end

endmodule

// File: logic/pc_unit.sv
module pc_unit import rv_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        pc_en,
    input  pc_sel_e     pc_sel,
    input  logic [31:0] imm,
    input  logic [31:0] rs1_plus_imm,
    output logic [31:0] pc
);
    logic [31:0] pc_next;

    always_comb begin
        case (pc_sel)
            pc_plus_imm:     pc_next = pc + imm;                        // jal, taken branch
            pc_reg_plus_imm: pc_next = {rs1_plus_imm[31:1], 1'b0};     // jalr
            default:         pc_next = pc + LINK_OFFSET;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= 32'h0;
        end else if (pc_en) begin
            pc <= pc_next;
        end
    end

endmodule

// File: logic/load_store_unit.sv
module load_store_unit import rv_pkg::*; #(
    parameter int DMEM_ADDR_W = 10
) (
    input  logic [DMEM_ADDR_W-1:0] addr_low,
    input  logic [2:0]             funct3,
    input  logic [31:0]            rs2_data,
    input  logic [31:0]            rdata,
    output logic [31:0]            wdata,
    output logic [3:0]             be,
    output logic [31:0]            load_data
);
    logic [1:0]  offset;
    logic [31:0] rdata_shifted;

    assign offset = addr_low[1:0];   // byte lane inside the word

    // store bytes move up to the addressed lane
    assign wdata = rs2_data << {offset, 3'b000};

    always_comb begin
        case (funct3[1:0])
            F3_B[1:0]: be = 4'b0001 << offset;
            F3_H[1:0]: be = 4'b0011 << offset;
            default:   be = 4'b1111;
        endcase
    end

    // addressed lanes come down to bit 0
    assign rdata_shifted = rdata >> {offset, 3'b000};

    always_comb begin
        case (funct3)
            F3_B:    load_data = {{24{rdata_shifted[7]}}, rdata_shifted[7:0]};
            F3_H:    load_data = {{16{rdata_shifted[15]}}, rdata_shifted[15:0]};
            F3_BU:   load_data = {24'h0, rdata_shifted[7:0]};
            F3_HU:   load_data = {16'h0, rdata_shifted[15:0]};
            default: load_data = rdata_shifted;   // lw
        endcase
    end

endmodule

// File: logic/datapath.sv
module datapath import rv_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  ctrl_t       ctrl,
    input  logic [31:0] load_data,
    input  logic [31:0] pc,
    output logic [31:0] alu_result,
    output logic [31:0] rs2_data,
    output logic        zero,
    output logic        negative,
    output logic        overflow
);
    logic [31:0] regs [32];
    logic [31:0] rs1_data;
    logic [31:0] alu_b;
    logic [31:0] wb_data;

    assign rs1_data = (ctrl.rs1 == 5'd0) ? 32'h0 : regs[ctrl.rs1];   // x0 reads zero
    assign rs2_data = (ctrl.rs2 == 5'd0) ? 32'h0 : regs[ctrl.rs2];
    assign alu_b    = ctrl.use_imm ? ctrl.imm : rs2_data;

    alu u_alu (
        .a        (rs1_data),
        .b        (alu_b),
        .op       (ctrl.alu_op),
        .result   (alu_result),
        .zero     (zero),
        .negative (negative),
        .overflow (overflow)
    );

    always_comb begin
        case (ctrl.wb_sel)
            wb_alu:  wb_data = alu_result;
            wb_load: wb_data = load_data;
            wb_link: wb_data = pc + LINK_OFFSET;
            default: wb_data = ctrl.imm;   // lui, auipc already pc-added
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_n && ctrl.reg_write && ctrl.rd != 5'd0) begin
            regs[ctrl.rd] <= wb_data;
        end
    end

endmodule

// File: logic/alu.sv
module alu import rv_pkg::*; (
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  alu_op_e     op,
    output logic [31:0] result,
    output logic        zero,
    output logic        negative,
    output logic        overflow
);
    logic        sub;
    logic [31:0] b_eff;
    logic [31:0] sum;

    assign sub   = (op == alu_sub);
    assign b_eff = sub ? ~b : b;
    assign sum   = a + b_eff + {31'h0, sub};   // two's complement subtract

    always_comb begin
        case (op)
            alu_add,
            alu_sub:  result = sum;
            alu_sll:  result = a << b[4:0];
            alu_slt:  result = {31'h0, $signed(a) < $signed(b)};
            alu_sltu: result = {31'h0, a < b};
            alu_xor:  result = a ^ b;
            alu_srl:  result = a >> b[4:0];
            alu_sra:  result = $signed(a) >>> b[4:0];
            alu_or:   result = a | b;
            alu_and:  result = a & b;
            default:  result = sum;
        endcase
    end

    assign zero     = (result == 32'h0);
    assign negative = result[31];
    // operands of equal sign giving a sum of the other sign
    assign overflow = (a[31] == b_eff[31]) && (sum[31] != a[31]);

endmodule

// File: logic/rv_pkg.sv
package rv_pkg;

    // major opcodes, the all-zero word stops the core
    typedef enum logic [6:0] {
        op_halt   = 7'b0000000,
        op_load   = 7'b0000011,
        op_i      = 7'b0010011,
        op_auipc  = 7'b0010111,
        op_store  = 7'b0100011,
        op_r      = 7'b0110011,
        op_lui    = 7'b0110111,
        op_branch = 7'b1100011,
        op_jalr   = 7'b1100111,
        op_jal    = 7'b1101111
    } opcode_e;

    // {funct7[5], funct3}
    typedef enum logic [3:0] {
        alu_add  = 4'b0000,
        alu_sll  = 4'b0001,
        alu_slt  = 4'b0010,
        alu_sltu = 4'b0011,
        alu_xor  = 4'b0100,
        alu_srl  = 4'b0101,
        alu_or   = 4'b0110,
        alu_and  = 4'b0111,
        alu_sub  = 4'b1000,
        alu_sra  = 4'b1101
    } alu_op_e;

    typedef enum logic [3:0] {
        st_fetch,
        st_decode,
        st_execute,
        st_write_back,
        st_next_pc,
        st_mem_req,
        st_mem_wait,
        st_branch,
        st_halt
    } core_state_e;

    typedef enum logic [1:0] {
        pc_plus4,
        pc_plus_imm,
        pc_reg_plus_imm
    } pc_sel_e;

    typedef enum logic [1:0] {
        wb_alu,
        wb_load,
        wb_link,
        wb_imm
    } wb_sel_e;

    typedef struct packed {
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        alu_op_e     alu_op;
        logic        use_imm;   // b operand from imm instead of rs2
        logic        reg_write;
        wb_sel_e     wb_sel;
        logic [2:0]  funct3;
        logic [31:0] imm;
    } ctrl_t;

    // addr holds the data address zero-extended from DMEM_ADDR_W bits
    typedef struct packed {
        logic [31:0] addr;
        logic        write;
        logic [3:0]  be;
        logic [31:0] wdata;
    } dmem_req_t;

    // funct3 values for branches, shifts and memory access sizes
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_B    = 3'b000;
    localparam logic [2:0] F3_H    = 3'b001;
    localparam logic [2:0] F3_BU   = 3'b100;
    localparam logic [2:0] F3_HU   = 3'b101;

    localparam logic [31:0] LINK_OFFSET = 32'd4;

endpackage
